/* hw/rvfi_pkg.sv */
package rvfi_pkg;

  // Datapath widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned CSR_ADDR_W = 12;

  // Retirement order count, wraps around
  localparam int unsigned ORDER_W = 16;

  // Kind of record presented to the trace sink
  typedef enum logic {
    KIND_INSTR = 1'b0,
    KIND_CSR   = 1'b1
  } trace_kind_e;

  // One retired instruction, 86 bits
  // rd_addr/rd_wdata are zero when no register is written or rd is x0
  typedef struct packed {
    logic [ORDER_W-1:0]    order;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic                  has_csr;
  } instr_rec_t;

  // One CSR write, 60 bits
  // Shares its order value with the owning instruction record
  typedef struct packed {
    logic [ORDER_W-1:0]    order;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       csr_wdata;
  } csr_rec_t;

endpackage

/* hw/rvfi_trace_fifo.sv */
module rvfi_trace_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         T_PAYLOAD = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     push_i,
  input  T_PAYLOAD push_data_i,
  input  logic     pop_i,

  output logic     full_o,
  output logic     empty_o,
  output T_PAYLOAD head_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

  if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
    $error("rvfi_trace_fifo: DEPTH must be a power of two and at least 2");
  end

  T_PAYLOAD         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;

  assign full_o  = (count_q == FULL_CNT);
  assign empty_o = (count_q == '0);
  assign head_o  = mem[rd_ptr_q];

  // Storage, pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Writer checks full in a different module, reader checks empty in another
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o
  ) else $error("push into full FIFO");

  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o
  ) else $error("pop from empty FIFO");

endmodule

/* hw/rvfi_retire_capture.sv */
module rvfi_retire_capture (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // Writeback retirement port
  input  logic                            wb_valid_i,
  output logic                            wb_ready_o,
  input  logic [rvfi_pkg::XLEN-1:0]       pc_wb_i,
  input  logic                            rf_we_wb_i,
  input  logic [rvfi_pkg::REG_ADDR_W-1:0] rf_addr_wb_i,
  input  logic [rvfi_pkg::XLEN-1:0]       rf_wdata_wb_i,
  input  logic                            csr_we_i,
  input  logic [rvfi_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]       csr_wdata_i,

  // Record FIFO write side
  input  logic                            instr_full_i,
  input  logic                            csr_full_i,
  output logic                            instr_push_o,
  output rvfi_pkg::instr_rec_t            instr_data_o,
  output logic                            csr_push_o,
  output rvfi_pkg::csr_rec_t              csr_data_o
);

  logic [rvfi_pkg::ORDER_W-1:0] order_q;
  logic                         accept;
  logic                         rd_valid;

  // Both FIFOs need room since a retirement may push into each
  assign wb_ready_o = !instr_full_i && !csr_full_i;
  assign accept     = wb_valid_i && wb_ready_o;

  // x0 writes and non-writing instructions report rd = 0, data = 0
  assign rd_valid = rf_we_wb_i && (rf_addr_wb_i != '0);

  assign instr_push_o = accept;
  assign csr_push_o   = accept && csr_we_i;

  always_comb begin
    instr_data_o.order    = order_q;
    instr_data_o.pc       = pc_wb_i;
    instr_data_o.rd_addr  = rd_valid ? rf_addr_wb_i : '0;
    instr_data_o.rd_wdata = rd_valid ? rf_wdata_wb_i : '0;
    instr_data_o.has_csr  = csr_we_i;

    csr_data_o.order      = order_q;
    csr_data_o.csr_addr   = csr_addr_i;
    csr_data_o.csr_wdata  = csr_wdata_i;
  end

  // Order count advances on the accepting edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      order_q <= '0;
    end else if (accept) begin
      order_q <= order_q + 1'b1;
    end
  end

  // A stalled source keeps its retirement steady until it is taken
  a_wb_hold_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i && !wb_ready_o |=>
      wb_valid_i &&
      $stable({pc_wb_i, rf_we_wb_i, rf_addr_wb_i, rf_wdata_wb_i,
               csr_we_i, csr_addr_i, csr_wdata_i})
  ) else $error("writeback fields changed while stalled");

endmodule

/* hw/rvfi_trace_emitter.sv */
module rvfi_trace_emitter (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  // Record FIFO read side
  input  logic                                   instr_empty_i,
  input  rvfi_pkg::instr_rec_t                   instr_head_i,
  output logic                                   instr_pop_o,
  input  logic                                   csr_empty_i,
  input  rvfi_pkg::csr_rec_t                     csr_head_i,
  output logic                                   csr_pop_o,

  // Four-phase trace port
  output logic                                   trace_req_o,
  input  logic                                   trace_ack_i,
  output rvfi_pkg::trace_kind_e                  trace_kind_o,
  output logic [rvfi_pkg::ORDER_W-1:0]           trace_order_o,
  output logic [rvfi_pkg::XLEN-1:0]              trace_pc_o,
  output logic [rvfi_pkg::REG_ADDR_W-1:0]        trace_rd_addr_o,
  output logic [rvfi_pkg::XLEN-1:0]              trace_rd_wdata_o,
  output logic [rvfi_pkg::CSR_ADDR_W-1:0]        trace_csr_addr_o,
  output logic [rvfi_pkg::XLEN-1:0]              trace_csr_wdata_o
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_ACK_LOW
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   pending_csr_q;
  logic   pending_csr_d;

  always_comb begin
    state_d       = state_q;
    pending_csr_d = pending_csr_q;
    instr_pop_o   = 1'b0;
    csr_pop_o     = 1'b0;
    case (state_q)
      IDLE: begin
        // Only start a new record once the sink has released ack
        if (!trace_ack_i) begin
          if (pending_csr_q) begin
            if (!csr_empty_i) begin
              csr_pop_o     = 1'b1;
              pending_csr_d = 1'b0;
              state_d       = REQ;
            end
          end else if (!instr_empty_i) begin
            instr_pop_o   = 1'b1;
            pending_csr_d = instr_head_i.has_csr;
            state_d       = REQ;
          end
        end
      end
      REQ: begin
        if (trace_ack_i) begin
          state_d = WAIT_ACK_LOW;
        end
      end
      WAIT_ACK_LOW: begin
        if (!trace_ack_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= IDLE;
      pending_csr_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      pending_csr_q <= pending_csr_d;
    end
  end

  assign trace_req_o = (state_q == REQ);

  // Output record is loaded together with the pop
  always_ff @(posedge clk_i) begin
    if (instr_pop_o) begin
      trace_kind_o      <= rvfi_pkg::KIND_INSTR;
      trace_order_o     <= instr_head_i.order;
      trace_pc_o        <= instr_head_i.pc;
      trace_rd_addr_o   <= instr_head_i.rd_addr;
      trace_rd_wdata_o  <= instr_head_i.rd_wdata;
      trace_csr_addr_o  <= '0;
      trace_csr_wdata_o <= '0;
    end else if (csr_pop_o) begin
      trace_kind_o      <= rvfi_pkg::KIND_CSR;
      trace_order_o     <= csr_head_i.order;
      trace_pc_o        <= '0;
      trace_rd_addr_o   <= '0;
      trace_rd_wdata_o  <= '0;
      trace_csr_addr_o  <= csr_head_i.csr_addr;
      trace_csr_wdata_o <= csr_head_i.csr_wdata;
    end
  end

  a_data_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    trace_req_o |=> !trace_req_o ||
      $stable({trace_kind_o, trace_order_o, trace_pc_o, trace_rd_addr_o,
               trace_rd_wdata_o, trace_csr_addr_o, trace_csr_wdata_o})
  ) else $error("trace data changed while req high");

  // Capture pushes the CSR record on the same edge as its instruction
  a_csr_ready : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (state_q == IDLE) && pending_csr_q |-> !csr_empty_i
  ) else $error("CSR record due but CSR FIFO empty");

endmodule

/* hw/rvfi_trace_top.sv */
module rvfi_trace_top #(
  parameter int unsigned INSTR_DEPTH = 4,
  parameter int unsigned CSR_DEPTH   = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // Writeback retirement port
  input  logic                            wb_valid_i,
  output logic                            wb_ready_o,
  input  logic [rvfi_pkg::XLEN-1:0]       pc_wb_i,
  input  logic                            rf_we_wb_i,
  input  logic [rvfi_pkg::REG_ADDR_W-1:0] rf_addr_wb_i,
  input  logic [rvfi_pkg::XLEN-1:0]       rf_wdata_wb_i,
  input  logic                            csr_we_i,
  input  logic [rvfi_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]       csr_wdata_i,

  // Trace sink port
  output logic                            trace_req_o,
  input  logic                            trace_ack_i,
  output rvfi_pkg::trace_kind_e           trace_kind_o,
  output logic [rvfi_pkg::ORDER_W-1:0]    trace_order_o,
  output logic [rvfi_pkg::XLEN-1:0]       trace_pc_o,
  output logic [rvfi_pkg::REG_ADDR_W-1:0] trace_rd_addr_o,
  output logic [rvfi_pkg::XLEN-1:0]       trace_rd_wdata_o,
  output logic [rvfi_pkg::CSR_ADDR_W-1:0] trace_csr_addr_o,
  output logic [rvfi_pkg::XLEN-1:0]       trace_csr_wdata_o
);

  logic                 instr_push;
  rvfi_pkg::instr_rec_t instr_push_data;
  logic                 instr_full;
  logic                 instr_empty;
  rvfi_pkg::instr_rec_t instr_head;
  logic                 instr_pop;

  logic                 csr_push;
  rvfi_pkg::csr_rec_t   csr_push_data;
  logic                 csr_full;
  logic                 csr_empty;
  rvfi_pkg::csr_rec_t   csr_head;
  logic                 csr_pop;

  rvfi_retire_capture u_capture (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wb_valid_i    (wb_valid_i),
    .wb_ready_o    (wb_ready_o),
    .pc_wb_i       (pc_wb_i),
    .rf_we_wb_i    (rf_we_wb_i),
    .rf_addr_wb_i  (rf_addr_wb_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .instr_full_i  (instr_full),
    .csr_full_i    (csr_full),
    .instr_push_o  (instr_push),
    .instr_data_o  (instr_push_data),
    .csr_push_o    (csr_push),
    .csr_data_o    (csr_push_data)
  );

  rvfi_trace_fifo #(
    .DEPTH     (INSTR_DEPTH),
    .T_PAYLOAD (rvfi_pkg::instr_rec_t)
  ) u_instr_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (instr_push),
    .push_data_i (instr_push_data),
    .pop_i       (instr_pop),
    .full_o      (instr_full),
    .empty_o     (instr_empty),
    .head_o      (instr_head)
  );

  rvfi_trace_fifo #(
    .DEPTH     (CSR_DEPTH),
    .T_PAYLOAD (rvfi_pkg::csr_rec_t)
  ) u_csr_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (csr_push),
    .push_data_i (csr_push_data),
    .pop_i       (csr_pop),
    .full_o      (csr_full),
    .empty_o     (csr_empty),
    .head_o      (csr_head)
  );

  rvfi_trace_emitter u_emitter (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .instr_empty_i     (instr_empty),
    .instr_head_i      (instr_head),
    .instr_pop_o       (instr_pop),
    .csr_empty_i       (csr_empty),
    .csr_head_i        (csr_head),
    .csr_pop_o         (csr_pop),
    .trace_req_o       (trace_req_o),
    .trace_ack_i       (trace_ack_i),
    .trace_kind_o      (trace_kind_o),
    .trace_order_o     (trace_order_o),
    .trace_pc_o        (trace_pc_o),
    .trace_rd_addr_o   (trace_rd_addr_o),
    .trace_rd_wdata_o  (trace_rd_wdata_o),
    .trace_csr_addr_o  (trace_csr_addr_o),
    .trace_csr_wdata_o (trace_csr_wdata_o)
  );

endmodule

/* include/tb_rvfi_model.svh */
`ifndef TB_RVFI_MODEL_SVH
`define TB_RVFI_MODEL_SVH

// One expected trace record, queued in the order the sink must see them
typedef struct {
  rvfi_pkg::trace_kind_e           kind;
  logic [rvfi_pkg::ORDER_W-1:0]    order;
  logic [rvfi_pkg::XLEN-1:0]       pc;
  logic [rvfi_pkg::REG_ADDR_W-1:0] rd_addr;
  logic [rvfi_pkg::XLEN-1:0]       rd_wdata;
  logic [rvfi_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic [rvfi_pkg::XLEN-1:0]       csr_wdata;
} exp_rec_t;

exp_rec_t                     exp_q[$];
logic [rvfi_pkg::ORDER_W-1:0] model_order = '0;

// Reference behavior for one accepted retirement
task automatic model_retire(
  input logic [rvfi_pkg::XLEN-1:0]       pc,
  input logic                            rf_we,
  input logic [rvfi_pkg::REG_ADDR_W-1:0] rd,
  input logic [rvfi_pkg::XLEN-1:0]       rd_wdata,
  input logic                            csr_we,
  input logic [rvfi_pkg::CSR_ADDR_W-1:0] csr_addr,
  input logic [rvfi_pkg::XLEN-1:0]       csr_wdata
);
  exp_rec_t rec;
  rec.kind      = rvfi_pkg::KIND_INSTR;
  rec.order     = model_order;
  rec.pc        = pc;
  rec.rd_addr   = '0;
  rec.rd_wdata  = '0;
  rec.csr_addr  = '0;
  rec.csr_wdata = '0;
  // Only a real register write shows up, x0 reads as no write
  if (rf_we && rd != 0) begin
    rec.rd_addr  = rd;
    rec.rd_wdata = rd_wdata;
  end
  exp_q.push_back(rec);
  if (csr_we) begin
    rec.kind      = rvfi_pkg::KIND_CSR;
    rec.pc        = '0;
    rec.rd_addr   = '0;
    rec.rd_wdata  = '0;
    rec.csr_addr  = csr_addr;
    rec.csr_wdata = csr_wdata;
    exp_q.push_back(rec);
  end
  model_order = model_order + 1'b1;
endtask

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
  if (actual !== expected) begin
    $display("Mismatch at %0t: %s actual 0x%0h expected 0x%0h",
             $time, name, actual, expected);
    abort_run();
  end
endtask

`endif

/* sim/tb_rvfi_trace.sv */
module tb_rvfi_trace;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_RETIRE  = 200;
  localparam int unsigned REQ_TIMEOUT = 100;
  localparam int unsigned ACK_TIMEOUT = 100;
  localparam int unsigned STALL_LIMIT = 5000;
  localparam int unsigned DRAIN_LIMIT = 50000;

  logic                            clk = 1'b0;
  logic                            rst_n;
  logic                            wb_valid;
  logic                            wb_ready;
  logic [rvfi_pkg::XLEN-1:0]       pc_wb;
  logic                            rf_we_wb;
  logic [rvfi_pkg::REG_ADDR_W-1:0] rf_addr_wb;
  logic [rvfi_pkg::XLEN-1:0]       rf_wdata_wb;
  logic                            csr_we;
  logic [rvfi_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic [rvfi_pkg::XLEN-1:0]       csr_wdata;
  logic                            trace_req;
  logic                            trace_ack;
  rvfi_pkg::trace_kind_e           trace_kind;
  logic [rvfi_pkg::ORDER_W-1:0]    trace_order;
  logic [rvfi_pkg::XLEN-1:0]       trace_pc;
  logic [rvfi_pkg::REG_ADDR_W-1:0] trace_rd_addr;
  logic [rvfi_pkg::XLEN-1:0]       trace_rd_wdata;
  logic [rvfi_pkg::CSR_ADDR_W-1:0] trace_csr_addr;
  logic [rvfi_pkg::XLEN-1:0]       trace_csr_wdata;

  integer      seed         = 32'h13bf;
  int unsigned stall_cycles = 0;

  `include "tb_rvfi_model.svh"

  always #50 clk = ~clk;

  rvfi_trace_top u_rvfi_trace_top (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .wb_valid_i        (wb_valid),
    .wb_ready_o        (wb_ready),
    .pc_wb_i           (pc_wb),
    .rf_we_wb_i        (rf_we_wb),
    .rf_addr_wb_i      (rf_addr_wb),
    .rf_wdata_wb_i     (rf_wdata_wb),
    .csr_we_i          (csr_we),
    .csr_addr_i        (csr_addr),
    .csr_wdata_i       (csr_wdata),
    .trace_req_o       (trace_req),
    .trace_ack_i       (trace_ack),
    .trace_kind_o      (trace_kind),
    .trace_order_o     (trace_order),
    .trace_pc_o        (trace_pc),
    .trace_rd_addr_o   (trace_rd_addr),
    .trace_rd_wdata_o  (trace_rd_wdata),
    .trace_csr_addr_o  (trace_csr_addr),
    .trace_csr_wdata_o (trace_csr_wdata)
  );

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  // Inputs change and outputs are read just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1ns;
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Mostly quick acks, now and then a long one to back up the FIFOs
  function automatic int unsigned ack_delay();
    if (rand_below(10) == 0) begin
      return 10 + rand_below(40);
    end
    return rand_below(3);
  endfunction

  task automatic compare_outputs(input exp_rec_t rec);
    check_value("trace_kind_o", trace_kind, rec.kind);
    check_value("trace_order_o", trace_order, rec.order);
    check_value("trace_pc_o", trace_pc, rec.pc);
    check_value("trace_rd_addr_o", trace_rd_addr, rec.rd_addr);
    check_value("trace_rd_wdata_o", trace_rd_wdata, rec.rd_wdata);
    check_value("trace_csr_addr_o", trace_csr_addr, rec.csr_addr);
    check_value("trace_csr_wdata_o", trace_csr_wdata, rec.csr_wdata);
  endtask

  task automatic send_retirement();
    int unsigned gap;
    int unsigned waited;
    logic        ready_now;
    gap = (rand_below(4) == 0) ? rand_below(4) : 0;
    if (gap != 0) begin
      wb_valid = 1'b0;
      repeat (gap) next_cycle();
    end
    pc_wb       = {$random(seed)} & 32'hffff_fffc;
    rf_we_wb    = (rand_below(4) != 0);
    // x0 as destination on about one in three
    rf_addr_wb  = (rand_below(3) == 0) ? 5'd0 : 5'(rand_below(32));
    rf_wdata_wb = $random(seed);
    csr_we      = (rand_below(4) == 0);
    csr_addr    = 12'(rand_below(4096));
    csr_wdata   = $random(seed);
    wb_valid    = 1'b1;
    waited      = 0;
    ready_now   = wb_ready;
    while (!ready_now) begin
      next_cycle();
      stall_cycles++;
      waited++;
      if (waited > STALL_LIMIT) begin
        $display("Source stalled for more than %0d cycles at %0t", STALL_LIMIT, $time);
        abort_run();
      end
      ready_now = wb_ready;
    end
    model_retire(pc_wb, rf_we_wb, rf_addr_wb, rf_wdata_wb, csr_we, csr_addr, csr_wdata);
    next_cycle();
  endtask

  // Sink side of one four-phase transfer
  task automatic serve_record();
    exp_rec_t    rec;
    int unsigned waited;
    int unsigned hold;
    waited = 0;
    while (!trace_req) begin
      next_cycle();
      waited = (exp_q.size() > 0) ? waited + 1 : 0;
      if (waited > REQ_TIMEOUT) begin
        $display("No trace_req_o within %0d cycles, %0d records outstanding",
                 REQ_TIMEOUT, exp_q.size());
        abort_run();
      end
    end
    if (exp_q.size() == 0) begin
      $display("Extra trace record at %0t with no retirement left to report", $time);
      abort_run();
    end
    rec = exp_q.pop_front();
    compare_outputs(rec);
    hold = ack_delay();
    repeat (hold) begin
      next_cycle();
      check_value("trace_req_o", trace_req, 1'b1);
      compare_outputs(rec);
    end
    trace_ack = 1'b1;
    waited    = 0;
    next_cycle();
    while (trace_req) begin
      compare_outputs(rec);
      waited++;
      if (waited > ACK_TIMEOUT) begin
        $display("trace_req_o still high %0d cycles after ack at %0t", ACK_TIMEOUT, $time);
        abort_run();
      end
      next_cycle();
    end
    // No new request while ack is still high
    hold = ack_delay();
    repeat (hold) begin
      next_cycle();
      check_value("trace_req_o", trace_req, 1'b0);
    end
    trace_ack = 1'b0;
  endtask

  task automatic run_sink();
    forever serve_record();
  endtask

  initial begin
    int unsigned waited;
    rst_n       = 1'b0;
    wb_valid    = 1'b0;
    pc_wb       = '0;
    rf_we_wb    = 1'b0;
    rf_addr_wb  = '0;
    rf_wdata_wb = '0;
    csr_we      = 1'b0;
    csr_addr    = '0;
    csr_wdata   = '0;
    trace_ack   = 1'b0;
    repeat (3) @(posedge clk);
    #1ns;
    rst_n = 1'b1;
    check_value("trace_req_o", trace_req, 1'b0);
    check_value("wb_ready_o", wb_ready, 1'b1);
    fork
      run_sink();
    join_none
    for (int i = 0; i < NUM_RETIRE; i++) begin
      send_retirement();
    end
    wb_valid = 1'b0;
    waited   = 0;
    while (exp_q.size() > 0 || trace_req || trace_ack) begin
      next_cycle();
      waited++;
      if (waited > DRAIN_LIMIT) begin
        $display("Trace did not drain, %0d records still expected", exp_q.size());
        abort_run();
      end
    end
    // Quiet period so a stray record would still be caught
    repeat (20) next_cycle();
    if (stall_cycles == 0) begin
      $display("Back-pressure never stalled the writeback source");
      abort_run();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* tb.f */
+incdir+include
hw/rvfi_pkg.sv
hw/rvfi_trace_fifo.sv
hw/rvfi_retire_capture.sv
hw/rvfi_trace_emitter.sv
hw/rvfi_trace_top.sv
sim/tb_rvfi_trace.sv
